// File: rtl/ifetch_pkg.sv
// ==========================================================================
// Instruction fetch front end shared definitions
// Widths, AHB-lite codes, the bus FSM states and the packed structs that
// pass between the fetch blocks and the consumer
// ==========================================================================
package ifetch_pkg;

	// Meaningful widths
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;
	// Fetch buffer fill in halfwords, 0 to 4
	typedef logic [2:0]  level_t;

	// ======================================================================
	// AHB-lite codes
	// ======================================================================

	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [2:0] HSIZE_WORD    = 3'b010;

	// Kind of data phase currently open on the bus
	typedef enum logic [1:0] {
		FS_IDLE    = 2'd0,
		FS_SEQ     = 2'd1,
		FS_JUMP_LO = 2'd2,
		FS_JUMP_HI = 2'd3
	} fetch_state_e;

	// Word landing this cycle, as seen by the fetch buffer
	typedef struct packed {
		logic fresh;
		logic after_jump;
		logic upper_only;
	} bus_rsp_t;

	// Instruction on offer to the consumer
	typedef struct packed {
		word_t instr;
		logic  is_32bit;
		addr_t pc;
	} instr_pkt_t;

endpackage

// File: rtl/fetch_pc_counter.sv
`timescale 1ns/10ps
// ==========================================================================
// Fetch address and PC counter
// Holds the next sequential word address to fetch and the PC of the
// instruction at the head of the fetch buffer
// ==========================================================================
module fetch_pc_counter #(
	parameter ifetch_pkg::addr_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              jump_now_i,
	input  ifetch_pkg::addr_t jump_target_i,
	input  logic              advance_i,
	input  logic              consume_i,
	input  logic              consume_32bit_i,
	output ifetch_pkg::addr_t fetch_addr_o,
	output ifetch_pkg::addr_t pc_o
);
	import ifetch_pkg::*;

	addr_t jump_word;
	addr_t pc_step;

	// The target word itself is being issued now, so sequential fetch
	// resumes one word later
	assign jump_word = {jump_target_i[31:2], 2'b00};

	// Halfword step for the instruction leaving the buffer
	assign pc_step = consume_32bit_i ? 32'd4 : 32'd2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr_o <= {RESET_VECTOR[31:2], 2'b00};
		end else if (jump_now_i) begin
			fetch_addr_o <= jump_word + 32'd4;
		end else if (advance_i) begin
			fetch_addr_o <= fetch_addr_o + 32'd4;
		end
	end

	// A handover on the jump edge is overridden by the new target
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_o <= RESET_VECTOR;
		end else if (jump_now_i) begin
			pc_o <= jump_target_i;
		end else if (consume_i) begin
			pc_o <= pc_o + pc_step;
		end
	end

endmodule

// File: rtl/ahb_fetch_fsm.sv
`timescale 1ns/10ps
// ==========================================================================
// AHB-lite fetch master
// Drives word-aligned NONSEQ reads, a jump target first and otherwise the
// next sequential word when the fetch buffer has room. The state register
// records which kind of data phase is open, so the returning word can be
// tagged for the buffer
// ==========================================================================
module ahb_fetch_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 hready_i,
	input  logic                 fetch_want_i,
	input  logic                 jump_i,
	input  ifetch_pkg::addr_t    jump_target_i,
	input  ifetch_pkg::addr_t    fetch_addr_i,
	output ifetch_pkg::addr_t    haddr_o,
	output logic [1:0]           htrans_o,
	output logic                 jump_now_o,
	output logic                 advance_o,
	output ifetch_pkg::bus_rsp_t rsp_o
);
	import ifetch_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;
	logic         run_q;
	logic         jump_req;
	logic         seq_req;

	// ======================================================================
	// Address phase
	// ======================================================================

	// Bus stays quiet until the first edge out of reset
	assign jump_req = run_q && jump_i;

	// At most one sequential word in flight. A held request stays up since
	// the buffer level can only fall while nothing lands
	assign seq_req = run_q && fetch_want_i && (state_q == FS_IDLE);

	// hready_i is kept out of this cone on purpose
	assign htrans_o = (jump_req || seq_req) ? HTRANS_NONSEQ : HTRANS_IDLE;
	assign haddr_o  = jump_req ? {jump_target_i[31:2], 2'b00} : fetch_addr_i;

	// Accept pulses for the counter and the buffer
	assign jump_now_o = jump_req && hready_i;
	assign advance_o  = seq_req && !jump_req && hready_i;

	// ======================================================================
	// Data phase tracking
	// ======================================================================

	always_comb begin
		if (jump_req) begin
			state_d = jump_target_i[1] ? FS_JUMP_HI : FS_JUMP_LO;
		end else if (seq_req) begin
			state_d = FS_SEQ;
		end else begin
			state_d = FS_IDLE;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= FS_IDLE;
			run_q   <= 1'b0;
		end else begin
			run_q <= 1'b1;
			// Wait states hold the open data phase
			if (hready_i) begin
				state_q <= state_d;
			end
		end
	end

	// Tag the word that completes this cycle
	always_comb begin
		rsp_o.fresh      = hready_i && (state_q != FS_IDLE);
		rsp_o.after_jump = (state_q == FS_JUMP_LO) || (state_q == FS_JUMP_HI);
		rsp_o.upper_only = (state_q == FS_JUMP_HI);
	end

endmodule

// File: rtl/fetch_buffer.sv
`timescale 1ns/10ps
// ==========================================================================
// Halfword fetch buffer
// Collects fetched words as up to four halfwords, finds the length of the
// head instruction and offers it aligned on a valid/ready handshake
// ==========================================================================
module fetch_buffer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  ifetch_pkg::word_t      hrdata_i,
	input  ifetch_pkg::bus_rsp_t   rsp_i,
	input  logic                   jump_now_i,
	input  ifetch_pkg::addr_t      pc_i,
	input  logic                   instr_ready_i,
	output logic                   fetch_want_o,
	output ifetch_pkg::instr_pkt_t instr_o,
	output logic                   instr_valid_o,
	output logic                   consume_o,
	output logic                   consume_32bit_o
);
	import ifetch_pkg::*;

	half_t [3:0] buf_q;
	half_t [3:0] buf_d;
	half_t [3:0] shifted;
	level_t      level_q;
	level_t      level_d;
	level_t      kept;
	level_t      base;
	level_t      add;
	logic [1:0]  loss;
	logic        head_32bit;
	logic        drop_lo;
	half_t       in_lo;
	half_t       in_hi;

	// ======================================================================
	// Head instruction
	// ======================================================================

	// Both low bits set marks a 32-bit encoding
	assign head_32bit = (buf_q[0][1:0] == 2'b11);

	assign instr_valid_o = head_32bit ? (level_q >= 3'd2) : (level_q != 3'd0);

	assign instr_o.instr    = head_32bit ? {buf_q[1], buf_q[0]} : {16'h0000, buf_q[0]};
	assign instr_o.is_32bit = head_32bit;
	assign instr_o.pc       = pc_i;

	assign consume_o       = instr_valid_o && instr_ready_i;
	assign consume_32bit_o = head_32bit;

	// Halfwords leaving this cycle
	assign loss = consume_o ? (head_32bit ? 2'd2 : 2'd1) : 2'd0;
	assign kept = level_q - level_t'(loss);

	// Only ask for a word that fits on top of what stays. Requests go out
	// with no data phase open, so no landing word needs counting here
	assign fetch_want_o = (kept <= 3'd2);

	// ======================================================================
	// Shift and append
	// ======================================================================

	always_comb begin
		unique case (loss)
			2'd1:    shifted = {16'h0000, buf_q[3:1]};
			2'd2:    shifted = {32'h0000_0000, buf_q[3:2]};
			default: shifted = buf_q;
		endcase
	end

	// An empty buffer whose PC sits in an upper half keeps only that half.
	// This covers both unaligned jumps and an unaligned reset vector
	assign drop_lo = rsp_i.upper_only || ((level_q == 3'd0) && pc_i[1]);

	assign in_lo = drop_lo ? hrdata_i[31:16] : hrdata_i[15:0];
	assign in_hi = hrdata_i[31:16];
	assign add   = drop_lo ? 3'd1 : 3'd2;

	// First word after a jump starts from an empty buffer
	assign base = rsp_i.after_jump ? 3'd0 : kept;

	always_comb begin
		buf_d = shifted;
		if (rsp_i.fresh) begin
			for (int i = 0; i < 4; i++) begin
				if (level_t'(i) == base) begin
					buf_d[i] = in_lo;
				end else if (level_t'(i) > base) begin
					buf_d[i] = in_hi;
				end
			end
		end
	end

	// Word completing on the jump edge belongs to the old stream
	always_comb begin
		if (jump_now_i) begin
			level_d = 3'd0;
		end else if (rsp_i.fresh) begin
			level_d = base + add;
		end else begin
			level_d = kept;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level_q <= 3'd0;
		end else begin
			level_q <= level_d;
		end
	end

	// Contents beyond level_q are don't care
	always_ff @(posedge clk) begin
		buf_q <= buf_d;
	end

endmodule

// File: rtl/rvc_fetch_unit.sv
`timescale 1ns/10ps
// ==========================================================================
// RV32IC instruction fetch unit
// AHB-lite word fetch, halfword realignment of 16/32-bit instructions,
// PC tracking and redirection by jump requests
// ==========================================================================
module rvc_fetch_unit #(
	parameter ifetch_pkg::addr_t RESET_VECTOR = 32'h0000_0000
) (
	input  logic                   clk,
	input  logic                   rst_n,

	// AHB-lite master
	output ifetch_pkg::addr_t      haddr_o,
	output logic [1:0]             htrans_o,
	output logic [2:0]             hsize_o,
	output logic                   hwrite_o,
	input  ifetch_pkg::word_t      hrdata_i,
	input  logic                   hready_i,

	// Consumer
	output ifetch_pkg::instr_pkt_t instr_o,
	output logic                   instr_valid_o,
	input  logic                   instr_ready_i,

	// Redirection
	input  logic                   jump_i,
	input  ifetch_pkg::addr_t      jump_target_i
);
	import ifetch_pkg::*;

	bus_rsp_t rsp;
	addr_t    fetch_addr;
	addr_t    pc;
	logic     fetch_want;
	logic     jump_now;
	logic     advance;
	logic     consume;
	logic     consume_32bit;

	// Read-only word master
	assign hsize_o  = HSIZE_WORD;
	assign hwrite_o = 1'b0;

	fetch_pc_counter #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_fetch_pc_counter (
		.clk             (clk),
		.rst_n           (rst_n),
		.jump_now_i      (jump_now),
		.jump_target_i   (jump_target_i),
		.advance_i       (advance),
		.consume_i       (consume),
		.consume_32bit_i (consume_32bit),
		.fetch_addr_o    (fetch_addr),
		.pc_o            (pc)
	);

	ahb_fetch_fsm u_ahb_fetch_fsm (
		.clk           (clk),
		.rst_n         (rst_n),
		.hready_i      (hready_i),
		.fetch_want_i  (fetch_want),
		.jump_i        (jump_i),
		.jump_target_i (jump_target_i),
		.fetch_addr_i  (fetch_addr),
		.haddr_o       (haddr_o),
		.htrans_o      (htrans_o),
		.jump_now_o    (jump_now),
		.advance_o     (advance),
		.rsp_o         (rsp)
	);

	fetch_buffer u_fetch_buffer (
		.clk             (clk),
		.rst_n           (rst_n),
		.hrdata_i        (hrdata_i),
		.rsp_i           (rsp),
		.jump_now_i      (jump_now),
		.pc_i            (pc),
		.instr_ready_i   (instr_ready_i),
		.fetch_want_o    (fetch_want),
		.instr_o         (instr_o),
		.instr_valid_o   (instr_valid_o),
		.consume_o       (consume),
		.consume_32bit_o (consume_32bit)
	);

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps
// ==========================================================================
// Testbench clock generator
// Free-running clock, low at time zero
// ==========================================================================
module tb_clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

// File: test/tb_fetch_checker.sv
`timescale 1ns/10ps
// ==========================================================================
// Fetch stream checker
// Follows the expected PC through handovers and jumps and compares each
// delivered instruction with the memory image. Also checks that a stalled
// offer holds steady
// ==========================================================================
module tb_fetch_checker #(
	parameter ifetch_pkg::addr_t RESET_VECTOR = 32'h0000_0000,
	parameter int                IMAGE_WORDS  = 1024
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  ifetch_pkg::word_t      mem_i [IMAGE_WORDS],
	input  ifetch_pkg::instr_pkt_t instr_i,
	input  logic                   instr_valid_i,
	input  logic                   instr_ready_i,
	input  logic                   jump_i,
	input  ifetch_pkg::addr_t      jump_target_i,
	input  logic                   hready_i,
	output int                     error_count_o,
	output int                     handover_count_o
);
	import ifetch_pkg::*;

	addr_t      exp_pc;
	addr_t      exp_step;
	logic       hold_pending;
	instr_pkt_t held_pkt;

	// Image is 4 KiB and addresses wrap inside it
	function automatic half_t half_at(input addr_t a);
		word_t w;
		w = mem_i[a[11:2]];
		return a[1] ? w[31:16] : w[15:0];
	endfunction

	task automatic report_mismatch(input string test_name, input word_t expected,
		input word_t actual);
		$display("FAILED %s: expected %08h, actual %08h at %0t", test_name, expected, actual,
			$time);
		error_count_o = error_count_o + 1;
	endtask

	task automatic check_handover();
		half_t lo;
		half_t hi;
		logic  exp_32;
		word_t exp_instr;
		lo        = half_at(exp_pc);
		hi        = half_at(exp_pc + 32'd2);
		exp_32    = (lo[1:0] == 2'b11);
		exp_instr = exp_32 ? {hi, lo} : {16'h0000, lo};
		exp_step  = exp_32 ? 32'd4 : 32'd2;
		if (instr_i.pc !== exp_pc) begin
			report_mismatch("stream_pc", exp_pc, instr_i.pc);
		end
		if (instr_i.is_32bit !== exp_32) begin
			report_mismatch("length", word_t'(exp_32), word_t'(instr_i.is_32bit));
		end
		if (instr_i.instr !== exp_instr) begin
			report_mismatch("instr", exp_instr, instr_i.instr);
		end
		handover_count_o = handover_count_o + 1;
	endtask

	// Sampled mid cycle, where all inputs and outputs are settled
	always @(negedge clk) begin
		if (!rst_n) begin
			exp_pc           = RESET_VECTOR;
			exp_step         = 32'd2;
			hold_pending     = 1'b0;
			held_pkt         = '0;
			error_count_o    = 0;
			handover_count_o = 0;
		end else begin
			if (hold_pending) begin
				if (!instr_valid_i) begin
					report_mismatch("hold_valid", 32'd1, 32'd0);
				end else begin
					if (instr_i.instr !== held_pkt.instr) begin
						report_mismatch("hold_instr", held_pkt.instr, instr_i.instr);
					end
					if (instr_i.pc !== held_pkt.pc) begin
						report_mismatch("hold_pc", held_pkt.pc, instr_i.pc);
					end
				end
			end
			if (instr_valid_i && instr_ready_i) begin
				check_handover();
				exp_pc = exp_pc + exp_step;
			end
			// A jump overrides the step of a handover on the same edge
			if (jump_i && hready_i) begin
				exp_pc = jump_target_i;
			end
			hold_pending = instr_valid_i && !instr_ready_i && !(jump_i && hready_i);
			held_pkt     = instr_i;
		end
	end

endmodule

// File: test/tb_fetch_assertions.sv
`timescale 1ns/10ps
// ==========================================================================
// Fetch unit bus and output assertions
// AHB-lite master rules and reset behaviour of the consumer side
// ==========================================================================
module tb_fetch_assertions (
	input logic              clk,
	input logic              rst_n,
	input ifetch_pkg::addr_t haddr_i,
	input logic [1:0]        htrans_i,
	input logic [2:0]        hsize_i,
	input logic              hwrite_i,
	input logic              hready_i,
	input logic              jump_i,
	input logic              instr_valid_i
);
	import ifetch_pkg::*;

	int error_count = 0;

	haddr_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		haddr_i[1:0] == 2'b00)
		else begin
			$error("haddr is not word aligned");
			error_count++;
		end

	hwrite_low: assert property (@(posedge clk) disable iff (!rst_n)
		!hwrite_i)
		else begin
			$error("hwrite is high on a read-only master");
			error_count++;
		end

	// AHB size code 3'b010 is a 32-bit transfer
	hsize_word: assert property (@(posedge clk) disable iff (!rst_n)
		hsize_i == 3'b010)
		else begin
			$error("hsize is not a word transfer");
			error_count++;
		end

	// Wait state holds the address phase, a newly raised jump may replace it
	addr_phase_held: assert property (@(posedge clk) disable iff (!rst_n)
		(htrans_i == HTRANS_NONSEQ) && !hready_i |=>
			(jump_i && !$past(jump_i)) ||
			((htrans_i == HTRANS_NONSEQ) && (haddr_i == $past(haddr_i))))
		else begin
			$error("address phase changed during a wait state");
			error_count++;
		end

	valid_low_in_reset: assert property (@(posedge clk)
		!rst_n |-> !instr_valid_i)
		else begin
			$error("instr_valid is high during reset");
			error_count++;
		end

endmodule

// File: test/tb_rvc_fetch.sv
`timescale 1ns/10ps
// ==========================================================================
// Fetch unit testbench top
// Random memory image behind an AHB-lite slave model, a random consumer
// with back-pressure, random jumps and a run limit in cycles
// ==========================================================================
module tb_rvc_fetch;
	import ifetch_pkg::*;

	// Unaligned start, so the first word only supplies its upper half
	localparam addr_t       RESET_VECTOR   = 32'h0000_0042;
	localparam int          IMAGE_WORDS    = 1024;
	localparam int          RESET_CYCLES   = 8;
	localparam int          NUM_HANDOVERS  = 3000;
	// About 3 cycles per handover are expected, so allow twice that plus slack
	localparam int          TIMEOUT_CYCLES = NUM_HANDOVERS * 6 + 2000;
	localparam int          DRIVE_DELAY_NS = 2;
	localparam logic [31:0] LCG_SEED       = 32'd88927;

	logic       clk;
	logic       rst_n;
	addr_t      haddr;
	logic [1:0] htrans;
	logic [2:0] hsize;
	logic       hwrite;
	word_t      hrdata;
	logic       hready;
	instr_pkt_t instr_pkt;
	logic       instr_valid;
	logic       instr_ready;
	logic       jump;
	addr_t      jump_target;

	word_t       mem [IMAGE_WORDS];
	logic [31:0] lcg_state;
	int          checker_errors;
	int          handovers;
	int          cycles;
	int          timeouts;
	int          total_errors;

	tb_clock_gen #(.PERIOD_NS(40)) u_tb_clock_gen (.clk_o(clk));

	rvc_fetch_unit #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_rvc_fetch_unit (
		.clk           (clk),
		.rst_n         (rst_n),
		.haddr_o       (haddr),
		.htrans_o      (htrans),
		.hsize_o       (hsize),
		.hwrite_o      (hwrite),
		.hrdata_i      (hrdata),
		.hready_i      (hready),
		.instr_o       (instr_pkt),
		.instr_valid_o (instr_valid),
		.instr_ready_i (instr_ready),
		.jump_i        (jump),
		.jump_target_i (jump_target)
	);

	tb_fetch_checker #(
		.RESET_VECTOR (RESET_VECTOR),
		.IMAGE_WORDS  (IMAGE_WORDS)
	) u_tb_fetch_checker (
		.clk              (clk),
		.rst_n            (rst_n),
		.mem_i            (mem),
		.instr_i          (instr_pkt),
		.instr_valid_i    (instr_valid),
		.instr_ready_i    (instr_ready),
		.jump_i           (jump),
		.jump_target_i    (jump_target),
		.hready_i         (hready),
		.error_count_o    (checker_errors),
		.handover_count_o (handovers)
	);

	bind rvc_fetch_unit tb_fetch_assertions u_fetch_assertions (
		.clk           (clk),
		.rst_n         (rst_n),
		.haddr_i       (haddr_o),
		.htrans_i      (htrans_o),
		.hsize_i       (hsize_o),
		.hwrite_i      (hwrite_o),
		.hready_i      (hready_i),
		.jump_i        (jump_i),
		.instr_valid_i (instr_valid_o)
	);

	// ======================================================================
	// Random numbers
	// ======================================================================

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper bits of the LCG have the longer period
	function automatic int unsigned rand_below(input int unsigned n);
		int unsigned r;
		r = lcg_next() >> 8;
		return r % n;
	endfunction

	task automatic fill_memory();
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			mem[i] = lcg_next();
		end
	endtask

	// One cycle of slave, consumer and jump requester, 2 ns after the edge
	task automatic drive_step(input logic accept, input addr_t addr, input logic jump_taken);
		int unsigned target_half;
		if (accept) begin
			hrdata = mem[addr[11:2]];
		end
		hready      = (rand_below(100) >= 30);
		instr_ready = (rand_below(100) >= 25);
		// Requester holds the jump until it is taken
		if (jump_taken) begin
			jump = 1'b0;
		end else if (!jump && (rand_below(40) == 0)) begin
			target_half = rand_below(IMAGE_WORDS * 2);
			jump        = 1'b1;
			jump_target = addr_t'(target_half) << 1;
		end
	endtask

	// ======================================================================
	// Bus slave, consumer and jumps
	// ======================================================================

	initial begin : stimulus
		logic  accept;
		addr_t accept_addr;
		logic  jump_taken;
		@(posedge rst_n);
		forever begin
			// Values here are the ones seen at the coming rising edge
			@(negedge clk);
			accept      = (htrans == HTRANS_NONSEQ) && hready;
			accept_addr = haddr;
			jump_taken  = jump && hready;
			@(posedge clk);
			#DRIVE_DELAY_NS;
			drive_step(accept, accept_addr, jump_taken);
		end
	end

	// ======================================================================
	// Reset, run limit and result
	// ======================================================================

	initial begin : run_control
		lcg_state   = LCG_SEED;
		rst_n       = 1'b0;
		hrdata      = '0;
		hready      = 1'b1;
		instr_ready = 1'b0;
		jump        = 1'b0;
		jump_target = '0;
		cycles      = 0;
		timeouts    = 0;
		fill_memory();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY_NS;
		rst_n = 1'b1;
		while ((handovers < NUM_HANDOVERS) && (cycles < TIMEOUT_CYCLES)) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		if (handovers < NUM_HANDOVERS) begin
			$display("Timeout: the fetch unit stalled, only %0d of %0d instructions in %0d cycles",
				handovers, NUM_HANDOVERS, cycles);
			timeouts = 1;
		end
		total_errors = checker_errors + u_rvc_fetch_unit.u_fetch_assertions.error_count + timeouts;
		$display("Error counts: checker %0d, assertions %0d, timeout %0d, handovers %0d",
			checker_errors, u_rvc_fetch_unit.u_fetch_assertions.error_count, timeouts, handovers);
		if (total_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: project.f
rtl/ifetch_pkg.sv
rtl/fetch_pc_counter.sv
rtl/ahb_fetch_fsm.sv
rtl/fetch_buffer.sv
rtl/rvc_fetch_unit.sv
test/tb_clock_gen.sv
test/tb_fetch_checker.sv
test/tb_fetch_assertions.sv
test/tb_rvc_fetch.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rvc_fetch
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Test passed"; \
	else \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
